//--- tile_bus_config.svh
/*
 * Build-time sizes of the compute tile shared bus.
 * Included by the package and by every module that sizes
 * ports or storage from these values.
 */
`ifndef TILE_BUS_CONFIG_SVH
`define TILE_BUS_CONFIG_SVH

// Byte address width
`define TILE_ADDR_W 32
// Data word width
`define TILE_DATA_W 32
// One select bit per byte lane
`define TILE_SEL_W 4

// Instruction and data port of one core
`define TILE_NUM_MASTERS 2

// Local SRAM depth in words
`define TILE_LMEM_WORDS 256
// Boot ROM depth in words
`define TILE_ROM_WORDS 8

`endif

//--- tile_bus_pkg.sv
/*
 * Types shared by the tile bus modules: bus vectors, the address
 * region and arbiter state encodings, and the boot image held in
 * the boot ROM. Modules import it inside their bodies.
 */
`include "tile_bus_config.svh"

package tile_bus_pkg;

   localparam int MASTER_ID_W = (`TILE_NUM_MASTERS > 1) ? $clog2(`TILE_NUM_MASTERS) : 1;

   typedef logic [`TILE_ADDR_W-1:0] bus_addr_t;
   typedef logic [`TILE_DATA_W-1:0] bus_data_t;
   typedef logic [`TILE_SEL_W-1:0]  bus_sel_t;
   typedef logic [MASTER_ID_W-1:0]  master_id_t;

   typedef enum logic [1:0] {
      REG_LMEM,   // Address bit 31 low
      REG_NA,     // Network adapter window, 0xE
      REG_ROM,    // Boot ROM, 0xF
      REG_NONE
   } region_e;

   typedef enum logic {
      ARB_IDLE,
      ARB_BUSY
   } arb_state_e;

   // Set up the stack, then jump into local memory at 0x100
   localparam bus_data_t BOOT_IMAGE [`TILE_ROM_WORDS] = '{
      32'h18200000, 32'hA82103F0, 32'h18600000, 32'hA8630100,
      32'h44001800, 32'h15000000, 32'h15000000, 32'h15000000
   };

endpackage

//--- wb_if.sv
/*
 * Single-master Wishbone classic bundle used between the tile bus
 * blocks. The master side drives the request, the slave side the
 * response; the monitor view only observes.
 */
interface wb_if;
   import tile_bus_pkg::*;

   bus_addr_t adr;
   bus_data_t dat_w;
   bus_sel_t  sel;
   logic      we;
   logic      cyc;
   logic      stb;
   logic      ack;
   logic      err;
   bus_data_t dat_r;

   modport master (output adr, dat_w, sel, we, cyc, stb,
                   input  ack, err, dat_r);

   modport slave (input  adr, dat_w, sel, we, cyc, stb,
                  output ack, err, dat_r);

   // Decoder and response mux only look at the bus
   modport monitor (input adr, dat_w, sel, we, cyc, stb, ack, err, dat_r);

endinterface

//--- bus_arbiter.sv
/*
 * Round-robin arbiter of the tile bus masters. A master that raises
 * cyc is granted one cycle later and keeps the bus until it drops
 * cyc. The granted request is copied onto the shared bus and the
 * response goes back to that master only.
 */
`include "tile_bus_config.svh"

module bus_arbiter #(
   parameter int NUM_MASTERS = `TILE_NUM_MASTERS
) (
   input  logic                                      clk,
   input  logic                                      rst_n_i,
   input  logic [NUM_MASTERS-1:0]                    m_cyc_i,
   input  logic [NUM_MASTERS-1:0]                    m_stb_i,
   input  logic [NUM_MASTERS-1:0]                    m_we_i,
   input  tile_bus_pkg::bus_addr_t [NUM_MASTERS-1:0] m_adr_i,
   input  tile_bus_pkg::bus_data_t [NUM_MASTERS-1:0] m_dat_i,
   input  tile_bus_pkg::bus_sel_t  [NUM_MASTERS-1:0] m_sel_i,
   output logic [NUM_MASTERS-1:0]                    m_ack_o,
   output logic [NUM_MASTERS-1:0]                    m_err_o,
   output tile_bus_pkg::bus_data_t [NUM_MASTERS-1:0] m_dat_o,
   wb_if.master                                      bus_o
);
   import tile_bus_pkg::*;

   arb_state_e state_q;
   master_id_t grant_q;     // Owner of the shared bus
   master_id_t prio_q;      // First candidate of the next round
   master_id_t pick;
   logic       pick_valid;
   logic       busy;

   // Search the requesters starting at the priority pointer
   always_comb begin
      int idx;
      pick       = prio_q;
      pick_valid = 1'b0;
      for (int i = 0; i < NUM_MASTERS; i++) begin
         idx = (int'(prio_q) + i) % NUM_MASTERS;
         if (!pick_valid && m_cyc_i[idx]) begin
            pick       = master_id_t'(idx);
            pick_valid = 1'b1;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= ARB_IDLE;
         grant_q <= '0;
         prio_q  <= '0;
      end else begin
         unique case (state_q)
            ARB_IDLE: if (pick_valid) begin
               grant_q <= pick;
               state_q <= ARB_BUSY;
            end
            ARB_BUSY: if (!m_cyc_i[grant_q]) begin
               state_q <= ARB_IDLE;   // Others get a turn next
               prio_q  <= master_id_t'((int'(grant_q) + 1) % NUM_MASTERS);
            end
         endcase
      end
   end

   assign busy = (state_q == ARB_BUSY);

   assign bus_o.cyc   = busy & m_cyc_i[grant_q];
   assign bus_o.stb   = busy & m_stb_i[grant_q];
   assign bus_o.we    = m_we_i[grant_q];
   assign bus_o.adr   = m_adr_i[grant_q];
   assign bus_o.dat_w = m_dat_i[grant_q];
   assign bus_o.sel   = m_sel_i[grant_q];

   always_comb begin
      for (int i = 0; i < NUM_MASTERS; i++) begin
         m_ack_o[i] = busy && (grant_q == master_id_t'(i)) && bus_o.ack;
         m_err_o[i] = busy && (grant_q == master_id_t'(i)) && bus_o.err;
         m_dat_o[i] = (busy && (grant_q == master_id_t'(i))) ? bus_o.dat_r : '0;
      end
   end

endmodule

//--- slave_decode.sv
/*
 * Address decoder of the shared tile bus. Classifies the address
 * into a region, passes the request to the SRAM or the boot ROM
 * with cyc and stb gated, and hands the region to the response mux.
 */
`include "tile_bus_config.svh"

module slave_decode (
   wb_if.monitor                  bus_i,
   wb_if.master                   mem_o,
   wb_if.master                   rom_o,
   output tile_bus_pkg::region_e  region_o
);
   import tile_bus_pkg::*;

   logic [3:0] top_nib;

   assign top_nib = bus_i.adr[`TILE_ADDR_W-1 -: 4];

   always_comb begin
      if (!bus_i.adr[`TILE_ADDR_W-1]) begin
         region_o = REG_LMEM;
      end else if (top_nib == 4'hE) begin
         region_o = REG_NA;   // No adapter here, answered with err
      end else if (top_nib == 4'hF) begin
         region_o = REG_ROM;
      end else begin
         region_o = REG_NONE;
      end
   end

   // Local memory port
   assign mem_o.cyc   = bus_i.cyc & (region_o == REG_LMEM);
   assign mem_o.stb   = bus_i.stb & (region_o == REG_LMEM);
   assign mem_o.we    = bus_i.we;
   assign mem_o.adr   = bus_i.adr;
   assign mem_o.dat_w = bus_i.dat_w;
   assign mem_o.sel   = bus_i.sel;

   // Boot ROM port
   assign rom_o.cyc   = bus_i.cyc & (region_o == REG_ROM);
   assign rom_o.stb   = bus_i.stb & (region_o == REG_ROM);
   assign rom_o.we    = bus_i.we;
   assign rom_o.adr   = bus_i.adr;
   assign rom_o.dat_w = bus_i.dat_w;
   assign rom_o.sel   = bus_i.sel;

endmodule

//--- local_sram.sv
/*
 * Word-organized local SRAM of the tile. Writes honor the byte
 * selects, reads return the addressed word. Every access is
 * acknowledged one cycle after the strobe; err is never raised.
 */
`include "tile_bus_config.svh"

module local_sram (
   input logic clk,
   input logic rst_n_i,
   wb_if.slave bus_i
);
   import tile_bus_pkg::*;

   localparam int IDX_W = $clog2(`TILE_LMEM_WORDS);
   localparam int OFS_W = $clog2(`TILE_SEL_W);

   bus_data_t        mem [`TILE_LMEM_WORDS];
   logic [IDX_W-1:0] idx;
   logic             access;
   logic             ack_q;
   bus_data_t        dat_q;

   assign idx    = bus_i.adr[OFS_W +: IDX_W];   // Wraps at the depth
   assign access = bus_i.cyc & bus_i.stb & ~ack_q;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= access;
      end
   end

   // Storage and read data
   always_ff @(posedge clk) begin
      if (access && bus_i.we) begin
         for (int b = 0; b < `TILE_SEL_W; b++) begin
            if (bus_i.sel[b]) begin
               mem[idx][8*b +: 8] <= bus_i.dat_w[8*b +: 8];
            end
         end
      end
      if (access && !bus_i.we) begin
         dat_q <= mem[idx];
      end
   end

   assign bus_i.ack   = ack_q;
   assign bus_i.err   = 1'b0;
   assign bus_i.dat_r = dat_q;

endmodule

//--- boot_rom.sv
/*
 * Boot ROM slave holding the package boot image. Reads are
 * acknowledged one cycle after the strobe; a write is answered
 * with err one cycle later and leaves the image untouched.
 */
`include "tile_bus_config.svh"

module boot_rom (
   input logic clk,
   input logic rst_n_i,
   wb_if.slave bus_i
);
   import tile_bus_pkg::*;

   localparam int IDX_W = $clog2(`TILE_ROM_WORDS);
   localparam int OFS_W = $clog2(`TILE_SEL_W);

   logic [IDX_W-1:0] idx;
   logic             access;
   logic             ack_q;
   logic             err_q;
   bus_data_t        dat_q;

   assign idx    = bus_i.adr[OFS_W +: IDX_W];
   assign access = bus_i.cyc & bus_i.stb & ~ack_q & ~err_q;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
      end else begin
         ack_q <= access & ~bus_i.we;
         err_q <= access & bus_i.we;   // Read only
      end
   end

   always_ff @(posedge clk) begin
      if (access && !bus_i.we) begin
         dat_q <= BOOT_IMAGE[idx];
      end
   end

   assign bus_i.ack   = ack_q;
   assign bus_i.err   = err_q;
   assign bus_i.dat_r = dat_q;

endmodule

//--- resp_mux.sv
/*
 * Response side of the shared tile bus. Picks ack, err and read
 * data from the slave of the decoded region. Strobes into the
 * network adapter window or unmapped space get err one cycle later.
 * Read data is forced to zero whenever err is returned.
 */
`include "tile_bus_config.svh"

module resp_mux (
   input logic                  clk,
   input logic                  rst_n_i,
   input tile_bus_pkg::region_e region_i,
   wb_if.monitor                mem_i,
   wb_if.monitor                rom_i,
   wb_if.slave                  bus_o
);
   import tile_bus_pkg::*;

   logic      unmapped;
   logic      na_err_q;   // Error for regions without a slave
   logic      ack;
   logic      err;
   bus_data_t dat;

   assign unmapped = (region_i == REG_NA) || (region_i == REG_NONE);

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         na_err_q <= 1'b0;
      end else begin
         na_err_q <= bus_o.cyc & bus_o.stb & unmapped & ~na_err_q;
      end
   end

   always_comb begin
      ack = 1'b0;
      err = 1'b0;
      dat = '0;
      unique case (region_i)
         REG_LMEM: begin
            ack = mem_i.ack;
            err = mem_i.err;
            dat = mem_i.dat_r;
         end
         REG_ROM: begin
            ack = rom_i.ack;
            err = rom_i.err;
            dat = rom_i.dat_r;
         end
         default: err = na_err_q;
      endcase
   end

   assign bus_o.ack   = ack;
   assign bus_o.err   = err;
   assign bus_o.dat_r = err ? '0 : dat;

endmodule

//--- compute_tile_bus.sv
/*
 * Shared Wishbone bus of the compute tile with its local SRAM and
 * boot ROM. Each master connects through its own set of plain
 * ports; by default these are the instruction and data port of
 * one core. The network adapter window answers with err.
 */
`include "tile_bus_config.svh"

module compute_tile_bus (
   input  logic                                            clk,
   input  logic                                            rst_n_i,
   input  logic [`TILE_NUM_MASTERS-1:0]                    m_cyc_i,
   input  logic [`TILE_NUM_MASTERS-1:0]                    m_stb_i,
   input  logic [`TILE_NUM_MASTERS-1:0]                    m_we_i,
   input  tile_bus_pkg::bus_addr_t [`TILE_NUM_MASTERS-1:0] m_adr_i,
   input  tile_bus_pkg::bus_data_t [`TILE_NUM_MASTERS-1:0] m_dat_i,
   input  tile_bus_pkg::bus_sel_t  [`TILE_NUM_MASTERS-1:0] m_sel_i,
   output logic [`TILE_NUM_MASTERS-1:0]                    m_ack_o,
   output logic [`TILE_NUM_MASTERS-1:0]                    m_err_o,
   output tile_bus_pkg::bus_data_t [`TILE_NUM_MASTERS-1:0] m_dat_o
);
   import tile_bus_pkg::*;

   region_e region;   // From the decoder to the response mux

   wb_if bus_if ();   // Shared bus after arbitration
   wb_if mem_if ();
   wb_if rom_if ();

   bus_arbiter #(
      .NUM_MASTERS (`TILE_NUM_MASTERS)
   ) u_arbiter (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .m_cyc_i (m_cyc_i),
      .m_stb_i (m_stb_i),
      .m_we_i  (m_we_i),
      .m_adr_i (m_adr_i),
      .m_dat_i (m_dat_i),
      .m_sel_i (m_sel_i),
      .m_ack_o (m_ack_o),
      .m_err_o (m_err_o),
      .m_dat_o (m_dat_o),
      .bus_o   (bus_if.master)
   );

   slave_decode u_decode (
      .bus_i    (bus_if.monitor),
      .mem_o    (mem_if.master),
      .rom_o    (rom_if.master),
      .region_o (region)
   );

   local_sram u_sram (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .bus_i   (mem_if.slave)
   );

   boot_rom u_bootrom (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .bus_i   (rom_if.slave)
   );

   resp_mux u_resp (
      .clk      (clk),
      .rst_n_i  (rst_n_i),
      .region_i (region),
      .mem_i    (mem_if.monitor),
      .rom_i    (rom_if.monitor),
      .bus_o    (bus_if.slave)
   );

endmodule

//--- tile_bus_asserts.sv
/*
 * Protocol assertions on the master side of the tile bus arbiter.
 * Attached to every bus_arbiter instance by the bind below.
 */
`include "tile_bus_config.svh"

module tile_bus_asserts #(
   parameter int NUM_MASTERS = `TILE_NUM_MASTERS
) (
   input logic                   clk,
   input logic                   rst_n_i,
   input logic [NUM_MASTERS-1:0] m_stb_i,
   input logic [NUM_MASTERS-1:0] m_ack_i,
   input logic [NUM_MASTERS-1:0] m_err_i
);

   ack_err_exclusive: assert property (
      @(posedge clk) disable iff (!rst_n_i) (m_ack_i & m_err_i) == '0
   ) else $error("ack and err high together");

   // A transfer ends after one response cycle
   ack_one_cycle: assert property (
      @(posedge clk) disable iff (!rst_n_i) (m_ack_i != '0) |=> (m_ack_i == '0)
   ) else $error("ack held for two cycles");

   err_one_cycle: assert property (
      @(posedge clk) disable iff (!rst_n_i) (m_err_i != '0) |=> (m_err_i == '0)
   ) else $error("err held for two cycles");

   // Only a master with its strobe up may see ack or err
   response_to_requester: assert property (
      @(posedge clk) disable iff (!rst_n_i) ((m_ack_i | m_err_i) & ~m_stb_i) == '0
   ) else $error("response seen by a master without a strobe");

endmodule

bind bus_arbiter tile_bus_asserts #(
   .NUM_MASTERS (NUM_MASTERS)
) u_asserts (
   .clk     (clk),
   .rst_n_i (rst_n_i),
   .m_stb_i (m_stb_i),
   .m_ack_i (m_ack_o),
   .m_err_i (m_err_o)
);

//--- tb_compute_tile_bus.sv
/*
 * Testbench of the compute tile bus. A table of single transfers is
 * built with expected responses from a reference model of the SRAM
 * and the boot ROM. The table runs in sections with one driver per
 * master working in parallel. The first mismatch stops the run.
 */
`include "tile_bus_config.svh"

module tb_compute_tile_bus;
   import tile_bus_pkg::*;

   localparam int CLK_PERIOD = 4;
   localparam int NM         = `TILE_NUM_MASTERS;

   typedef struct {
      string     name;
      int        master;
      bus_addr_t adr;
      logic      we;
      bus_sel_t  sel;
      bus_data_t wdat;
      bus_data_t exp_dat;
      logic      exp_err;
   } xfer_t;

   logic               clk;
   logic               rst_n_i;
   logic [NM-1:0]      m_cyc_i;
   logic [NM-1:0]      m_stb_i;
   logic [NM-1:0]      m_we_i;
   bus_addr_t [NM-1:0] m_adr_i;
   bus_data_t [NM-1:0] m_dat_i;
   bus_sel_t  [NM-1:0] m_sel_i;
   logic [NM-1:0]      m_ack_o;
   logic [NM-1:0]      m_err_o;
   bus_data_t [NM-1:0] m_dat_o;

   xfer_t     tbl [$];
   int        sec_end [$];                    // Index where each section stops
   bus_data_t lmem_model [`TILE_LMEM_WORDS];
   bus_data_t rom_model [`TILE_ROM_WORDS];
   bit        table_ready;

   compute_tile_bus dut_i (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .m_cyc_i (m_cyc_i),
      .m_stb_i (m_stb_i),
      .m_we_i  (m_we_i),
      .m_adr_i (m_adr_i),
      .m_dat_i (m_dat_i),
      .m_sel_i (m_sel_i),
      .m_ack_o (m_ack_o),
      .m_err_o (m_err_o),
      .m_dat_o (m_dat_o)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
      if (actual !== expected) begin
         $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
         $display("Verification failed");
         $fatal(1, "Stopping at the first mismatch");
      end
   endtask

   // Append one transfer with the response that the region rules and the model give
   function automatic void add_xfer(string name, int master, bus_addr_t adr, logic we,
                                    bus_sel_t sel, bus_data_t wdat);
      xfer_t x;
      int    w;
      x.name    = name;
      x.master  = master;
      x.adr     = adr;
      x.we      = we;
      x.sel     = sel;
      x.wdat    = wdat;
      x.exp_dat = '0;
      x.exp_err = 1'b1;                        // NA window, unmapped, ROM write
      if (!adr[`TILE_ADDR_W-1]) begin
         w         = int'(adr[`TILE_ADDR_W-1:2] % `TILE_LMEM_WORDS);
         x.exp_err = 1'b0;
         if (we) begin
            for (int b = 0; b < `TILE_SEL_W; b++) begin
               if (sel[b]) begin
                  lmem_model[w][8*b +: 8] = wdat[8*b +: 8];
               end
            end
         end else begin
            x.exp_dat = lmem_model[w];
         end
      end else if (adr[`TILE_ADDR_W-1 -: 4] == 4'hF && !we) begin
         x.exp_err = 1'b0;
         x.exp_dat = rom_model[int'(adr[`TILE_ADDR_W-1:2] % `TILE_ROM_WORDS)];
      end
      tbl.push_back(x);
   endfunction

   // An SRAM word always belongs to the master of its parity
   function automatic void build_table();
      int        words [8];
      int        w;
      bus_addr_t a;
      for (int i = 0; i < 8; i++) begin
         words[i] = int'($urandom % 128) * 2 + (i % 2);
         add_xfer("word_write", i % 2, bus_addr_t'(words[i] * 4), 1'b1, 4'hF, $urandom);
      end
      for (int i = 0; i < 8; i++) begin
         add_xfer("word_read", i % 2, bus_addr_t'(words[i] * 4), 1'b0, 4'hF, '0);
      end
      sec_end.push_back(tbl.size());
      for (int i = 0; i < 8; i++) begin
         a = bus_addr_t'(words[i] * 4);
         add_xfer("byte_write", i % 2, a, 1'b1, bus_sel_t'($urandom % 16), $urandom);
         add_xfer("byte_read", i % 2, a, 1'b0, 4'hF, '0);
      end
      sec_end.push_back(tbl.size());
      for (int i = 0; i < `TILE_ROM_WORDS; i++) begin
         add_xfer("rom_read", i % 2, bus_addr_t'(32'hF000_0000 + i * 4), 1'b0, 4'hF, '0);
      end
      add_xfer("rom_write", 0, 32'hF000_0008, 1'b1, 4'hF, $urandom);
      add_xfer("rom_reread", 0, 32'hF000_0008, 1'b0, 4'hF, '0);
      sec_end.push_back(tbl.size());
      for (int t = 8; t <= 14; t++) begin    // 0x8 to 0xD and the NA window
         a = ($urandom & 32'h0FFF_FFFC) | (bus_addr_t'(t) << 28);
         add_xfer("unmapped_write", t % 2, a, 1'b1, 4'hF, $urandom);
         add_xfer("unmapped_read", t % 2, a, 1'b0, 4'hF, '0);
      end
      sec_end.push_back(tbl.size());
      for (int i = 0; i < 8; i++) begin
         add_xfer("lmem_intact", i % 2, bus_addr_t'(words[i] * 4), 1'b0, 4'hF, '0);
      end
      sec_end.push_back(tbl.size());
      for (int i = 0; i < 12; i++) begin
         w = int'($urandom % 128) * 2 + (i % 2);
         a = bus_addr_t'(w * 4);
         add_xfer("dual_write", i % 2, a, 1'b1, 4'hF, $urandom);
         add_xfer("dual_read", i % 2, a, 1'b0, 4'hF, '0);
         add_xfer("dual_rom", i % 2, bus_addr_t'(32'hF000_0000 + i * 4), 1'b0, 4'hF, '0);
      end
      sec_end.push_back(tbl.size());
   endfunction

   // Runs the entries of master m in [lo, hi) one transfer at a time
   task automatic drive_master(int m, int lo, int hi);
      xfer_t     x;
      logic      ack;
      logic      err;
      bus_data_t dat;
      for (int i = lo; i < hi; i++) begin
         if (tbl[i].master == m) begin
            x = tbl[i];
            @(posedge clk);
            m_cyc_i[m] <= 1'b1;
            m_stb_i[m] <= 1'b1;
            m_we_i[m]  <= x.we;
            m_adr_i[m] <= x.adr;
            m_dat_i[m] <= x.wdat;
            m_sel_i[m] <= x.sel;
            do begin
               @(negedge clk);                 // Outputs settled here
               ack = m_ack_o[m];
               err = m_err_o[m];
               dat = m_dat_o[m];
            end while (!ack && !err);
            @(posedge clk);
            m_cyc_i[m] <= 1'b0;
            m_stb_i[m] <= 1'b0;
            check_value({x.name, " err"}, 32'(x.exp_err), 32'(err));
            check_value({x.name, " ack"}, 32'(!x.exp_err), 32'(ack));
            if (!x.we || x.exp_err) begin
               check_value({x.name, " data"}, x.exp_dat, dat);
            end
         end
      end
   endtask

   // A response may only reach a master that has its strobe up
   initial begin
      wait (rst_n_i);
      forever begin
         @(negedge clk);
         check_value("stray_response", '0, 32'((m_ack_o | m_err_o) & ~m_stb_i));
      end
   end

   initial begin
      wait (table_ready);
      #((tbl.size() * 20 + 10) * CLK_PERIOD);
      $display("Timeout: a bus transfer never finished");
      $display("Verification failed");
      $fatal(1, "Watchdog expired");
   end

   initial begin
      int lo;
      void'($urandom(93671));
      table_ready = 1'b0;
      rst_n_i     = 1'b0;
      m_cyc_i     = '0;
      m_stb_i     = '0;
      m_we_i      = '0;
      m_adr_i     = '0;
      m_dat_i     = '0;
      m_sel_i     = '0;
      rom_model   = BOOT_IMAGE;
      build_table();
      table_ready = 1'b1;
      repeat (3) @(posedge clk);
      rst_n_i <= 1'b1;
      lo = 0;
      foreach (sec_end[s]) begin
         fork
            drive_master(0, lo, sec_end[s]);
            drive_master(1, lo, sec_end[s]);
         join
         lo = sec_end[s];
      end
      $display("Verification passed");
      $finish;
   end

endmodule

//--- vlog.f
+incdir+.
tile_bus_pkg.sv
wb_if.sv
bus_arbiter.sv
slave_decode.sv
local_sram.sv
boot_rom.sv
resp_mux.sv
compute_tile_bus.sv
tile_bus_asserts.sv
tb_compute_tile_bus.sv

//--- run.sh
#!/bin/sh
# Builds the tile bus testbench with Verilator and runs it.
# The exit status is the simulator's own.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f \
   --top-module tb_compute_tile_bus -o tb_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit $status
fi

./obj_dir/tb_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation ended with status $status"
   exit $status
fi

exit 0
